/* Makefile */
VERILATOR ?= verilator
TOP       ?= fetch_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* hdl/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

    // datapath and address width
    localparam int unsigned xlen = 64;

    // uncompressed instruction width
    localparam int unsigned ilen = 32;

    // first pc after reset
    localparam logic [xlen-1:0] reset_vector = 64'h8000_0000;

    // redirect request from the memory stage
    // strobes are one cycle wide, operands are valid with them
    typedef struct packed {
        // unconditional pc-relative jump
        logic            jal;
        // register-indirect jump, bit 0 of the target is cleared
        logic            jalr;
        // conditional branch, taken only with branch_zero
        logic            branch;
        // trap entry to mtvec
        logic            trap;
        // branch comparison result was zero
        logic            branch_zero;
        // pc of the redirecting instruction
        logic [xlen-1:0] pc;
        // sign-extended immediate
        logic [xlen-1:0] imm;
        // rs1 operand for jalr
        logic [xlen-1:0] rs1;
        // trap vector base
        logic [xlen-1:0] mtvec;
    } redirect_t;

    // fetched instruction handed to decode
    typedef struct packed {
        // one-cycle pulse per delivered instruction
        logic            valid;
        // address the word was fetched from
        logic [xlen-1:0] pc;
        // selected 32-bit half of the beat
        logic [ilen-1:0] inst;
    } fetch_out_t;

endpackage

`default_nettype wire

/* hdl/fetch_req.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_req (
    input  wire                          clk,
    input  wire                          rst_n_i,
    input  wire [fetch_pkg::xlen-1:0]    pc_i,
    input  wire                          flush_i,
    input  wire                          stall_i,
    output logic                         ar_valid_o,
    input  wire                          ar_ready_i,
    output logic [fetch_pkg::xlen-1:0]   ar_addr_o,
    input  wire                          r_valid_i,
    output logic                         r_ready_o,
    input  wire [fetch_pkg::xlen-1:0]    r_data_i,
    output logic                         advance_o,
    output fetch_pkg::fetch_out_t        fetch_o
);

    // request controller states
    typedef enum logic [1:0] {
        state_idle = 2'd0,
        state_addr = 2'd1,
        state_data = 2'd2
    } state_t;

    state_t                     state_q;
    state_t                     state_d;

    // address of the outstanding request
    logic [fetch_pkg::xlen-1:0] addr_q;
    logic [fetch_pkg::xlen-1:0] addr_d;
    logic                       addr_load;

    // set when a redirect hits a pending request
    logic                       stale_q;
    logic                       stale_d;

    // handshake strobes
    logic                       ar_fire;
    logic                       r_fire;
    logic                       beat_good;

    // selected instruction half
    logic [fetch_pkg::ilen-1:0] inst_sel;

    // output register
    logic                       out_valid_q;
    logic [fetch_pkg::xlen-1:0] out_pc_q;
    logic [fetch_pkg::ilen-1:0] out_inst_q;

    assign ar_valid_o = (state_q == state_addr);
    assign r_ready_o  = (state_q == state_data);
    assign ar_addr_o  = addr_q;

    assign ar_fire = ar_valid_o & ar_ready_i;
    assign r_fire  = r_valid_i & r_ready_o;

    // a flush in the beat cycle also kills the beat
    assign beat_good = r_fire & ~stale_q & ~flush_i;
    assign advance_o = beat_good & ~stall_i;

    always_comb begin
        state_d   = state_q;
        addr_d    = pc_i;
        addr_load = 1'b0;
        stale_d   = stale_q;
        case (state_q)
            state_idle: begin
                // wait one cycle on flush so the new pc is used
                if (!stall_i && !flush_i) begin
                    state_d   = state_addr;
                    addr_load = 1'b1;
                end
            end
            state_addr: begin
                if (flush_i) begin
                    stale_d = 1'b1;
                end
                if (ar_fire) begin
                    state_d = state_data;
                end
            end
            state_data: begin
                if (flush_i) begin
                    stale_d = 1'b1;
                end
                if (r_fire) begin
                    stale_d = 1'b0;
                    if (flush_i || stall_i) begin
                        // refetch once the pc settles or the stall clears
                        state_d = state_idle;
                    end else begin
                        // pc moves by 4 at this same edge when advancing
                        state_d   = state_addr;
                        addr_load = 1'b1;
                        addr_d    = advance_o ? pc_i + 64'd4 : pc_i;
                    end
                end
            end
            default: begin
                state_d = state_idle;
                stale_d = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= state_idle;
            stale_q <= 1'b0;
        end else begin
            state_q <= state_d;
            stale_q <= stale_d;
        end
    end

    // held stable while ar_valid_o is up
    always_ff @(posedge clk) begin
        if (addr_load) begin
            addr_q <= addr_d;
        end
    end

    // bit 2 picks the upper word of the 64-bit beat
    assign inst_sel = addr_q[2] ? r_data_i[63:32] : r_data_i[31:0];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            out_valid_q <= 1'b0;
        end else begin
            out_valid_q <= beat_good;
        end
    end

    always_ff @(posedge clk) begin
        if (beat_good) begin
            out_pc_q   <= addr_q;
            out_inst_q <= inst_sel;
        end
    end

    assign fetch_o = '{valid: out_valid_q, pc: out_pc_q, inst: out_inst_q};

endmodule

`default_nettype wire

/* hdl/fetch_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
    input  wire                          clk,
    input  wire                          rst_n_i,
    // redirect and hold from later stages
    input  wire fetch_pkg::redirect_t    redirect_i,
    input  wire                          stall_i,
    // read address channel
    output logic                         ar_valid_o,
    input  wire                          ar_ready_i,
    output logic [fetch_pkg::xlen-1:0]   ar_addr_o,
    // read data channel
    input  wire                          r_valid_i,
    output logic                         r_ready_o,
    input  wire [fetch_pkg::xlen-1:0]    r_data_i,
    // to decode
    output fetch_pkg::fetch_out_t        fetch_o
);

    logic [fetch_pkg::xlen-1:0] pc;
    logic                       flush;
    logic                       advance;

    // pc register and redirect selection
    pc_redirect pc_redirect_inst (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .redirect_i (redirect_i),
        .advance_i  (advance),
        .pc_o       (pc),
        .flush_o    (flush)
    );

    // memory read handshakes and output register
    fetch_req fetch_req_inst (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .pc_i       (pc),
        .flush_i    (flush),
        .stall_i    (stall_i),
        .ar_valid_o (ar_valid_o),
        .ar_ready_i (ar_ready_i),
        .ar_addr_o  (ar_addr_o),
        .r_valid_i  (r_valid_i),
        .r_ready_o  (r_ready_o),
        .r_data_i   (r_data_i),
        .advance_o  (advance),
        .fetch_o    (fetch_o)
    );

endmodule

`default_nettype wire

/* hdl/pc_redirect.sv */
`timescale 1ns/1ps
`default_nettype none

module pc_redirect (
    input  wire                        clk,
    input  wire                        rst_n_i,
    input  wire fetch_pkg::redirect_t  redirect_i,
    input  wire                        advance_i,
    output logic [fetch_pkg::xlen-1:0] pc_o,
    output logic                       flush_o
);

    // program counter
    logic [fetch_pkg::xlen-1:0] pc_q;
    logic [fetch_pkg::xlen-1:0] pc_d;

    // redirect target candidates
    logic [fetch_pkg::xlen-1:0] rel_target;
    logic [fetch_pkg::xlen-1:0] reg_sum;
    logic [fetch_pkg::xlen-1:0] reg_target;
    logic [fetch_pkg::xlen-1:0] seq_target;

    // decoded redirect conditions
    logic                       branch_taken;
    logic                       take_rel;
    logic                       take_reg;
    logic                       take_trap;

    // a branch only redirects when the comparison came out zero
    assign branch_taken = redirect_i.branch & redirect_i.branch_zero;

    // priority is jal/branch, then jalr, then trap
    assign take_rel  = redirect_i.jal | branch_taken;
    assign take_reg  = ~take_rel & redirect_i.jalr;
    assign take_trap = ~take_rel & ~redirect_i.jalr & redirect_i.trap;

    // pc-relative target for jal and taken branches
    assign rel_target = redirect_i.pc + redirect_i.imm;

    // jalr target with bit 0 forced low
    assign reg_sum    = redirect_i.rs1 + redirect_i.imm;
    assign reg_target = {reg_sum[fetch_pkg::xlen-1:1], 1'b0};

    // next sequential instruction
    assign seq_target = pc_q + 64'd4;

    always_comb begin
        if (take_rel) begin
            pc_d = rel_target;
        end else if (take_reg) begin
            pc_d = reg_target;
        end else if (take_trap) begin
            pc_d = redirect_i.mtvec;
        end else if (advance_i) begin
            // redirect wins over advance, handled by the order above
            pc_d = seq_target;
        end else begin
            pc_d = pc_q;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q <= fetch_pkg::reset_vector;
        end else begin
            pc_q <= pc_d;
        end
    end

    // flush in the same cycle the redirect is seen
    // request side marks whatever is in flight as stale
    assign flush_o = take_rel | take_reg | take_trap;

    assign pc_o = pc_q;

endmodule

`default_nettype wire

/* verif/fetch_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_tb;

    localparam int clk_period   = 4;
    localparam int table_len    = 11;
    // generous per-entry bound for back-pressure and a stall
    localparam int entry_cycles = 400;

    typedef enum logic [2:0] {
        act_none,
        act_stall,
        act_jal,
        act_branch_taken,
        act_branch_not_taken,
        act_jalr,
        act_trap
    } action_t;

    // base is pc for jal and branch, rs1 for jalr, mtvec for trap
    typedef struct packed {
        logic [7:0]                 seq_count;
        action_t                    action;
        logic [7:0]                 stall_cycles;
        logic [fetch_pkg::xlen-1:0] base;
        logic [fetch_pkg::xlen-1:0] imm;
        logic [fetch_pkg::xlen-1:0] exp_pc;
    } entry_t;

    logic                       clk;
    logic                       rst_n;
    logic                       stall;
    fetch_pkg::redirect_t       redirect;
    logic                       ar_valid;
    logic                       ar_ready;
    logic [fetch_pkg::xlen-1:0] ar_addr;
    logic                       r_valid;
    logic                       r_ready;
    logic [fetch_pkg::xlen-1:0] r_data;
    fetch_pkg::fetch_out_t      fetch_out;

    entry_t                     stim [table_len];
    logic                       redir_taken;
    logic [fetch_pkg::xlen-1:0] redir_target;
    int                         setup_errors;

    // monitor state
    logic [fetch_pkg::xlen-1:0] exp_pc       = fetch_pkg::reset_vector;
    logic                       beat_stalled = 1'b0;
    logic                       stall_q      = 1'b0;
    logic                       arv_q        = 1'b0;
    logic                       addr_sent    = 1'b0;
    int                         delivered    = 0;
    int                         stale_hits   = 0;
    int                         pc_errors    = 0;
    int                         inst_errors  = 0;
    int                         proto_errors = 0;

    fetch_stage fetch_stage_inst (
        .clk        (clk),
        .rst_n_i    (rst_n),
        .redirect_i (redirect),
        .stall_i    (stall),
        .ar_valid_o (ar_valid),
        .ar_ready_i (ar_ready),
        .ar_addr_o  (ar_addr),
        .r_valid_i  (r_valid),
        .r_ready_o  (r_ready),
        .r_data_i   (r_data),
        .fetch_o    (fetch_out)
    );

    imem_model imem_inst (
        .clk        (clk),
        .rst_n_i    (rst_n),
        .ar_valid_i (ar_valid),
        .ar_ready_o (ar_ready),
        .ar_addr_i  (ar_addr),
        .r_valid_o  (r_valid),
        .r_ready_i  (r_ready),
        .r_data_o   (r_data)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // same word layout as the memory model
    function automatic logic [31:0] expected_word(input logic [63:0] addr);
        expected_word = {addr[15:0], addr[31:16]} ^ addr[63:32] ^ 32'h0013_0013;
    endfunction

    function automatic logic redirect_strobe(input fetch_pkg::redirect_t r);
        redirect_strobe = r.jal | r.jalr | r.branch | r.trap;
    endfunction

    task automatic fill_table();
        // deliveries before acting, action, stall cycles, base, imm, next pc
        stim[0]  = '{8'd4, act_none, 8'd0, 64'h0, 64'h0, 64'h0};
        stim[1]  = '{8'd2, act_jal, 8'd0, 64'h8000_0014, 64'h100, 64'h8000_0114};
        stim[2]  = '{8'd3, act_branch_taken, 8'd0, 64'h8000_0200,
                     64'hffff_ffff_ffff_ffc0, 64'h8000_01c0};
        // a not-taken branch keeps the sequence
        stim[3]  = '{8'd3, act_branch_not_taken, 8'd0, 64'h8000_0300, 64'h80, 64'h0};
        // odd sum 0x8000_0421
        stim[4]  = '{8'd3, act_jalr, 8'd0, 64'h8000_0401, 64'h20, 64'h8000_0420};
        stim[5]  = '{8'd2, act_stall, 8'd6, 64'h0, 64'h0, 64'h0};
        stim[6]  = '{8'd3, act_trap, 8'd0, 64'h8000_1000, 64'h0, 64'h8000_1000};
        stim[7]  = '{8'd2, act_stall, 8'd3, 64'h0, 64'h0, 64'h0};
        stim[8]  = '{8'd2, act_jalr, 8'd0, 64'h8000_3000, 64'h105, 64'h8000_3104};
        stim[9]  = '{8'd5, act_jal, 8'd0, 64'h8000_3200, 64'h4000, 64'h8000_7200};
        stim[10] = '{8'd4, act_none, 8'd0, 64'h0, 64'h0, 64'h0};
    endtask

    // starts and ends on a rising edge
    task automatic run_entry(input entry_t e);
        fetch_pkg::redirect_t r;
        int                   target;
        target = delivered + int'(e.seq_count);
        while (delivered < target) begin
            @(posedge clk);
        end
        r = '0;
        case (e.action)
            act_stall: begin
                stall <= 1'b1;
                repeat (e.stall_cycles) @(posedge clk);
                stall <= 1'b0;
            end
            act_jal: begin
                r.jal = 1'b1;
                r.pc  = e.base;
            end
            act_branch_taken: begin
                r.branch      = 1'b1;
                r.branch_zero = 1'b1;
                r.pc          = e.base;
            end
            act_branch_not_taken: begin
                r.branch = 1'b1;
                r.pc     = e.base;
            end
            act_jalr: begin
                r.jalr = 1'b1;
                r.rs1  = e.base;
            end
            act_trap: begin
                r.trap  = 1'b1;
                r.mtvec = e.base;
            end
            default: begin
                r = '0;
            end
        endcase
        r.imm = e.imm;
        if (redirect_strobe(r)) begin
            redirect     <= r;
            redir_taken  <= (e.action != act_branch_not_taken);
            redir_target <= e.exp_pc;
            @(posedge clk);
            redirect <= '0;
        end
    endtask

    // delivery checks and the expected pc sequence
    always @(posedge clk) begin
        if (rst_n) begin
            if (fetch_out.valid) begin
                if (fetch_out.pc !== exp_pc) begin
                    pc_errors = pc_errors + 1;
                    $display("FAILED %0t: delivered pc %h, expected %h",
                             $time, fetch_out.pc, exp_pc);
                end
                if (fetch_out.inst !== expected_word(exp_pc)) begin
                    inst_errors = inst_errors + 1;
                    $display("FAILED %0t: inst %h at pc %h, expected %h",
                             $time, fetch_out.inst, exp_pc, expected_word(exp_pc));
                end
                // a beat taken under stall comes again after it
                if (!beat_stalled) begin
                    exp_pc = exp_pc + 64'd4;
                end
                delivered <= delivered + 1;
            end
            if (redirect_strobe(redirect) && redir_taken) begin
                exp_pc = redir_target;
                if (ar_valid || r_ready) begin
                    stale_hits <= stale_hits + 1;
                end
            end
            if (stall_q && !arv_q && ar_valid) begin
                proto_errors = proto_errors + 1;
                $display("FAILED %0t: new read address raised during stall", $time);
            end
            if (r_ready && !addr_sent) begin
                proto_errors = proto_errors + 1;
                $display("FAILED %0t: read data ready without an address transfer", $time);
            end
            if (ar_valid && ar_ready) begin
                addr_sent <= 1'b1;
            end else if (r_valid && r_ready) begin
                addr_sent <= 1'b0;
            end
            if (r_valid && r_ready) begin
                beat_stalled <= stall;
            end
            stall_q <= stall;
            arv_q   <= ar_valid;
        end
    end

    initial begin
        #(table_len * entry_cycles * clk_period);
        $display("watchdog: no result after %0d ns, run stopped",
                 table_len * entry_cycles * clk_period);
        $display("Test failed");
        $finish;
    end

    initial begin
        int total;
        rst_n        <= 1'b0;
        stall        <= 1'b0;
        redirect     <= '0;
        redir_taken  <= 1'b0;
        redir_target <= '0;
        setup_errors = 0;
        fill_table();
        repeat (4) begin
            @(posedge clk);
            if (ar_valid || r_ready || fetch_out.valid) begin
                setup_errors = setup_errors + 1;
                $display("FAILED %0t: ar_valid_o, r_ready_o or fetch_o.valid high in reset",
                         $time);
            end
        end
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);
        if (!ar_valid || ar_addr !== fetch_pkg::reset_vector) begin
            setup_errors = setup_errors + 1;
            $display("FAILED %0t: first request valid %b addr %h, expected addr %h",
                     $time, ar_valid, ar_addr, fetch_pkg::reset_vector);
        end
        for (int i = 0; i < table_len; i++) begin
            run_entry(stim[i]);
        end
        // monitor work of the last rising edge is complete here
        @(negedge clk);
        if (stale_hits == 0) begin
            setup_errors = setup_errors + 1;
            $display("no redirect arrived while a request was outstanding");
        end
        total = pc_errors + inst_errors + proto_errors + setup_errors;
        $display("errors: pc %0d, inst %0d, handshake %0d, setup %0d; deliveries %0d",
                 pc_errors, inst_errors, proto_errors, setup_errors, delivered);
        if (total == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/imem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module imem_model (
    input  wire                        clk,
    input  wire                        rst_n_i,
    // read address channel
    input  wire                        ar_valid_i,
    output logic                       ar_ready_o,
    input  wire [fetch_pkg::xlen-1:0]  ar_addr_i,
    // read data channel
    output logic                       r_valid_o,
    input  wire                        r_ready_i,
    output logic [fetch_pkg::xlen-1:0] r_data_o
);

    int                         seed = 32'h209d;
    logic [31:0]                rnd;

    // one request in flight, then a random data delay
    logic                       busy_q;
    logic [1:0]                 delay_q;
    logic                       ar_ready_q;
    logic                       r_valid_q;
    logic [fetch_pkg::xlen-1:0] r_data_q;

    // memory content, every bit of the address takes part
    function automatic logic [31:0] mem_word(input logic [63:0] addr);
        mem_word = {addr[15:0], addr[31:16]} ^ addr[63:32] ^ 32'h0013_0013;
    endfunction

    // aligned 64-bit beat, lower word at the lower address
    function automatic logic [63:0] mem_beat(input logic [63:0] addr);
        logic [63:0] base;
        base     = {addr[63:3], 3'b000};
        mem_beat = {mem_word(base + 64'd4), mem_word(base)};
    endfunction

    always @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ar_ready_q <= 1'b0;
            r_valid_q  <= 1'b0;
            r_data_q   <= '0;
            busy_q     <= 1'b0;
            delay_q    <= 2'd0;
        end else begin
            rnd = $random(seed);
            if (ar_valid_i && ar_ready_q) begin
                // address taken, close the channel until the beat is gone
                ar_ready_q <= 1'b0;
                busy_q     <= 1'b1;
                delay_q    <= rnd[1:0];
                r_data_q   <= mem_beat(ar_addr_i);
            end else if (!busy_q) begin
                // ready about three cycles out of four
                ar_ready_q <= rnd[2] | rnd[3];
            end
            if (busy_q && !r_valid_q) begin
                if (delay_q == 2'd0) begin
                    r_valid_q <= 1'b1;
                end else begin
                    delay_q <= delay_q - 2'd1;
                end
            end
            if (r_valid_q && r_ready_i) begin
                r_valid_q <= 1'b0;
                busy_q    <= 1'b0;
            end
        end
    end

    // quiet outputs while reset is low
    assign ar_ready_o = rst_n_i & ar_ready_q;
    assign r_valid_o  = rst_n_i & r_valid_q;
    assign r_data_o   = rst_n_i ? r_data_q : '0;

endmodule

`default_nettype wire

/* vlog.f */
hdl/fetch_pkg.sv
hdl/pc_redirect.sv
hdl/fetch_req.sv
hdl/fetch_stage.sv
verif/imem_model.sv
verif/fetch_tb.sv
